//--- imul_pkg.sv
//--------------------------------------
// shared types and sizes for the multiply array
// NUM_LANES must be a power of two, 2 to 8
//--------------------------------------
`default_nettype none

package imul_pkg;

  //--------------------------------------
  // sizes
  //--------------------------------------

  // parallel shift-and-add lanes
  localparam int NUM_LANES = 4;

  // bits needed to name one lane
  localparam int LANE_IDX_W = $clog2(NUM_LANES);

  // one shift-and-add step per operand bit
  localparam int ITERATIONS = 32;

  //--------------------------------------
  // types
  //--------------------------------------

  // request operand, two's complement
  typedef logic signed [31:0] operand_t;

  // full-width signed product
  typedef logic signed [63:0] product_t;

  // pointer into the lane array
  typedef logic [LANE_IDX_W-1:0] lane_idx_t;

  // lane control FSM
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    DONE = 2'd2
  } lane_state_e;

endpackage

`default_nettype wire

//--- imul_lane.sv
//--------------------------------------
// one signed 32x32 multiply lane, 32 shift-add steps, one request at a time
// resp_val rises on the 32nd edge after the accept edge (33rd cycle counting it)
// operands are sampled on the accept edge only
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module imul_lane (
  input  logic               clk,
  input  logic               reset,

  input  imul_pkg::operand_t req_a,
  input  imul_pkg::operand_t req_b,
  input  logic               req_val,
  output logic               req_rdy,

  output imul_pkg::product_t resp_product,
  output logic               resp_val,
  input  logic               resp_rdy
);

  import imul_pkg::*;

  // control state
  lane_state_e state;
  logic [4:0]  count;

  // datapath registers
  logic [63:0] a_reg;
  logic [31:0] b_reg;
  logic [63:0] result_reg;
  logic        neg_q;

  // handshake events
  logic req_go;
  logic resp_go;

  // operand magnitudes and the partial product for this step
  logic [31:0] a_mag;
  logic [31:0] b_mag;
  logic [63:0] add_term;

  assign req_rdy = (state == IDLE);
  assign resp_val = (state == DONE);

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  //--------------------------------------
  // control FSM
  //--------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      count <= 5'd0;
    end else begin
      case (state)
        IDLE: begin
          if (req_go) begin
            state <= CALC;
            count <= 5'd0;
          end
        end
        CALC: begin
          // last step taken on this edge
          if (count == 5'(ITERATIONS - 1)) begin
            state <= DONE;
          end
          count <= count + 5'd1;
        end
        DONE: begin
          // product consumed, free for the next request
          if (resp_go) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  //--------------------------------------
  // datapath
  //--------------------------------------

  // magnitudes; most negative maps to 2**31, still fits unsigned 32 bits
  assign a_mag = req_a[31] ? (~req_a + 32'd1) : req_a;
  assign b_mag = req_b[31] ? (~req_b + 32'd1) : req_b;

  // add shifted a when the current low bit of b is set
  assign add_term = b_reg[0] ? a_reg : 64'd0;

  always_ff @(posedge clk) begin
    if (req_go) begin
      a_reg      <= {32'd0, a_mag};
      b_reg      <= b_mag;
      result_reg <= 64'd0;
      // sign is kept here, port operands may change during CALC
      neg_q      <= req_a[31] ^ req_b[31];
    end else if (state == CALC) begin
      a_reg      <= a_reg << 1;
      b_reg      <= b_reg >> 1;
      result_reg <= result_reg + add_term;
    end
  end

  // two's complement negate of the unsigned magnitude
  assign resp_product = neg_q ? (~result_reg + 64'd1) : result_reg;

  //--------------------------------------
  // checks
  //--------------------------------------

  // a lane never offers to take a request while it holds a result
  a_rdy_val_excl : assert property (
    @(posedge clk) disable iff (reset)
    !(resp_val && req_rdy)
  );

  // stalled response keeps valid and data until the collector takes it
  a_resp_hold : assert property (
    @(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_product))
  );

endmodule

`default_nettype wire

//--- imul_dispatch.sv
//--------------------------------------
// round-robin request steering, one lane per transfer
// a busy lane under the pointer stalls the port, later lanes are not tried
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module imul_dispatch (
  input  logic                            clk,
  input  logic                            reset,

  input  logic                            req_val,
  output logic                            req_rdy,

  output logic [imul_pkg::NUM_LANES-1:0] lane_req_val,
  input  logic [imul_pkg::NUM_LANES-1:0] lane_req_rdy
);

  import imul_pkg::*;

  // lane that gets the next request
  lane_idx_t ptr;
  lane_idx_t ptr_next;

  //--------------------------------------
  // steering
  //--------------------------------------

  // only the pointed lane sees the request
  always_comb begin
    lane_req_val      = '0;
    lane_req_val[ptr] = req_val;
  end

  // top ready is just the pointed lane being idle
  assign req_rdy = lane_req_rdy[ptr];

  // wrap after the last lane
  always_comb begin
    if (ptr == lane_idx_t'(NUM_LANES - 1)) begin
      ptr_next = '0;
    end else begin
      ptr_next = ptr + lane_idx_t'(1);
    end
  end

  //--------------------------------------
  // pointer
  //--------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      ptr <= '0;
    end else if (req_val && req_rdy) begin
      ptr <= ptr_next;
    end
  end

  // at most one lane is offered a request
  a_req_onehot : assert property (
    @(posedge clk) disable iff (reset)
    $onehot0(lane_req_val)
  );

endmodule

`default_nettype wire

//--- imul_collect.sv
//--------------------------------------
// in-order response drain, same round-robin order as the dispatcher
// a lane that finishes early waits until the pointer reaches it
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module imul_collect (
  input  logic                                 clk,
  input  logic                                 reset,

  input  logic [imul_pkg::NUM_LANES-1:0]       lane_resp_val,
  input  imul_pkg::product_t [imul_pkg::NUM_LANES-1:0] lane_resp_product,
  output logic [imul_pkg::NUM_LANES-1:0]       lane_resp_rdy,

  output imul_pkg::product_t                   resp_product,
  output logic                                 resp_val,
  input  logic                                 resp_rdy
);

  import imul_pkg::*;

  // lane holding the oldest outstanding request
  lane_idx_t ptr;
  lane_idx_t ptr_next;

  //--------------------------------------
  // selection
  //--------------------------------------

  assign resp_val     = lane_resp_val[ptr];
  assign resp_product = lane_resp_product[ptr];

  // ready goes back to the pointed lane only
  always_comb begin
    lane_resp_rdy      = '0;
    lane_resp_rdy[ptr] = resp_rdy;
  end

  always_comb begin
    if (ptr == lane_idx_t'(NUM_LANES - 1)) begin
      ptr_next = '0;
    end else begin
      ptr_next = ptr + lane_idx_t'(1);
    end
  end

  //--------------------------------------
  // pointer
  //--------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      ptr <= '0;
    end else if (resp_val && resp_rdy) begin
      ptr <= ptr_next;
    end
  end

  // never release two lanes on one edge
  a_rdy_onehot : assert property (
    @(posedge clk) disable iff (reset)
    $onehot0(lane_resp_rdy)
  );

endmodule

`default_nettype wire

//--- imul_array.sv
//--------------------------------------
// multi-lane signed multiply, val/rdy on both sides, responses in request order
// unloaded latency matches one lane, see imul_lane
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module imul_array (
  input  logic               clk,
  input  logic               reset,

  input  imul_pkg::operand_t req_a,
  input  imul_pkg::operand_t req_b,
  input  logic               req_val,
  output logic               req_rdy,

  output imul_pkg::product_t resp_product,
  output logic               resp_val,
  input  logic               resp_rdy
);

  import imul_pkg::*;

  // dispatcher side
  logic [NUM_LANES-1:0] lane_req_val;
  logic [NUM_LANES-1:0] lane_req_rdy;

  // collector side
  logic [NUM_LANES-1:0]     lane_resp_val;
  logic [NUM_LANES-1:0]     lane_resp_rdy;
  product_t [NUM_LANES-1:0] lane_resp_product;

  imul_dispatch imul_dispatch_inst (
    .clk          (clk),
    .reset        (reset),
    .req_val      (req_val),
    .req_rdy      (req_rdy),
    .lane_req_val (lane_req_val),
    .lane_req_rdy (lane_req_rdy)
  );

  // operands go to every lane, only the selected one latches them
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    imul_lane imul_lane_inst (
      .clk          (clk),
      .reset        (reset),
      .req_a        (req_a),
      .req_b        (req_b),
      .req_val      (lane_req_val[i]),
      .req_rdy      (lane_req_rdy[i]),
      .resp_product (lane_resp_product[i]),
      .resp_val     (lane_resp_val[i]),
      .resp_rdy     (lane_resp_rdy[i])
    );
  end

  imul_collect imul_collect_inst (
    .clk               (clk),
    .reset             (reset),
    .lane_resp_val     (lane_resp_val),
    .lane_resp_product (lane_resp_product),
    .lane_resp_rdy     (lane_resp_rdy),
    .resp_product      (resp_product),
    .resp_val          (resp_val),
    .resp_rdy          (resp_rdy)
  );

endmodule

`default_nettype wire

//--- imul_tb.sv
//--------------------------------------
// testbench for imul_array, vectors from imul_testdata.txt in the project root
// responses checked in request order under random resp_rdy back-pressure
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module imul_tb;

  import imul_pkg::*;

  // DUT ports, every input has a defined value at time zero
  logic     clk = 1'b0;
  logic     reset = 1'b1;
  operand_t req_a;
  operand_t req_b;
  logic     req_val;
  logic     req_rdy;
  product_t resp_product;
  logic     resp_val;
  logic     resp_rdy;

  // vectors from the data file
  operand_t vec_a[$];
  operand_t vec_b[$];
  product_t vec_p[$];
  int       num_vec = 0;

  // shared by the driver and the resp_rdy process
  int seed = 32'h5438;

  // bookkeeping
  int       cycle = 0;
  int       cycle_limit = 1000000;
  int       resp_count = 0;
  int       mismatch_count = 0;
  int       other_errors = 0;
  int       first_accept_edge = 0;
  logic     first_seen = 1'b0;
  logic     stall_prev = 1'b0;
  product_t held_product;

  imul_array imul_array_inst (
    .clk          (clk),
    .reset        (reset),
    .req_a        (req_a),
    .req_b        (req_b),
    .req_val      (req_val),
    .req_rdy      (req_rdy),
    .resp_product (resp_product),
    .resp_val     (resp_val),
    .resp_rdy     (resp_rdy)
  );

  // 20 ns period
  always #10 clk = ~clk;

  //--------------------------------------
  // checks and reporting
  //--------------------------------------

  task automatic check_product(input string name, input product_t got, input product_t exp);
    if (got !== exp) begin
      mismatch_count++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      mismatch_count++;
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      mismatch_count++;
      $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic report_and_finish();
    int missing;
    missing = (resp_count < num_vec) ? (num_vec - resp_count) : 0;
    $display("mismatches: %0d, missing responses: %0d, other errors: %0d",
             mismatch_count, missing, other_errors);
    if (mismatch_count == 0 && missing == 0 && other_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  endtask

  // one vector per non-comment line, a b product in hex
  task automatic load_vectors();
    int       fd;
    int       rc;
    string    line;
    operand_t a;
    operand_t b;
    product_t p;
    product_t a_ext;
    product_t b_ext;
    fd = $fopen("imul_testdata.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("ERROR: could not open imul_testdata.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        rc = $fgets(line, fd);
        if (rc > 0 && line.getc(0) != "#") begin
          if ($sscanf(line, "%h %h %h", a, b, p) == 3) begin
            // sign extended, so this is the true signed product
            a_ext = product_t'(a);
            b_ext = product_t'(b);
            if (a_ext * b_ext != p) begin
              other_errors++;
              $display("ERROR: data file gives %h for %h times %h, which is wrong", p, a, b);
            end
            vec_a.push_back(a);
            vec_b.push_back(b);
            vec_p.push_back(p);
          end
        end
      end
      $fclose(fd);
    end
    num_vec = vec_a.size();
  endtask

  //--------------------------------------
  // cycle counter and timeout
  //--------------------------------------

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= cycle_limit) begin
      other_errors++;
      $display("ERROR: timeout after %0d cycles with %0d of %0d responses received",
               cycle, resp_count, num_vec);
      report_and_finish();
    end
  end

  //--------------------------------------
  // request driver
  //--------------------------------------

  initial begin : main_flow
    int gap;
    req_val = 1'b0;
    req_a   = '0;
    req_b   = '0;
    load_vectors();
    // worst case per vector plus reset and a long stall
    cycle_limit = 40 * num_vec + 200;
    if (num_vec == 0) begin
      other_errors++;
      $display("ERROR: no test vectors were loaded");
      report_and_finish();
    end else begin
      repeat (3) @(posedge clk);
      #1;
      reset = 1'b0;
      // idle state right after reset
      @(negedge clk);
      check_bit("resp_val", resp_val, 1'b0);
      check_bit("req_rdy", req_rdy, 1'b1);
      @(posedge clk);
      for (int i = 0; i < num_vec; i++) begin
        // drawn on the edge, resp_rdy draws 1 ns later
        gap = $unsigned($random(seed)) % 3;
        if (gap != 0) begin
          #1;
          req_val = 1'b0;
          // flipped operands on the port, the lane must not care
          req_a = ~req_a;
          req_b = ~req_b;
          repeat (gap) @(posedge clk);
        end
        #1;
        req_a   = vec_a[i];
        req_b   = vec_b[i];
        req_val = 1'b1;
        @(negedge clk);
        // all lanes still idle for the first round
        if (i < NUM_LANES) begin
          check_bit("req_rdy", req_rdy, 1'b1);
        end
        while (!req_rdy) begin
          @(negedge clk);
        end
        if (i == 0) begin
          first_accept_edge = cycle + 1;
        end
        // transfer edge
        @(posedge clk);
      end
      #1;
      req_val = 1'b0;
      req_a   = ~req_a;
      req_b   = ~req_b;
      wait (resp_count >= num_vec);
      // extra responses would show up here
      repeat (40) @(posedge clk);
      report_and_finish();
    end
  end

  //--------------------------------------
  // response back-pressure
  //--------------------------------------

  initial begin : rdy_driver
    logic long_stall_done;
    long_stall_done = 1'b0;
    resp_rdy = 1'b1;
    wait (!reset);
    forever begin
      @(posedge clk);
      #1;
      if (resp_count == 0) begin
        // free path for the first latency check
        resp_rdy = 1'b1;
      end else if (resp_count >= 8 && !long_stall_done) begin
        // long enough for every lane to reach DONE
        long_stall_done = 1'b1;
        resp_rdy = 1'b0;
        repeat (60) @(posedge clk);
        #1;
        resp_rdy = 1'b1;
      end else begin
        // ready about three cycles in four
        resp_rdy = (($random(seed) & 3) != 0);
      end
    end
  end

  //--------------------------------------
  // response monitor, mid-cycle sampling
  //--------------------------------------

  always @(negedge clk) begin
    if (!reset) begin
      // a stalled response holds valid and data
      if (stall_prev) begin
        check_bit("resp_val", resp_val, 1'b1);
        check_product("resp_product", resp_product, held_product);
      end
      // edge that samples the first resp_val against the accept edge
      if (resp_val && !first_seen) begin
        first_seen = 1'b1;
        check_count("first response latency", cycle + 1 - first_accept_edge, ITERATIONS + 1);
      end
      // transfer happens on the next rising edge
      if (resp_val && resp_rdy) begin
        if (resp_count < num_vec) begin
          check_product("resp_product", resp_product, vec_p[resp_count]);
        end else begin
          other_errors++;
          $display("ERROR: response at %0t arrived after all vectors were answered", $time);
        end
        resp_count++;
      end
      stall_prev   = resp_val && !resp_rdy;
      held_product = resp_product;
    end
  end

endmodule

`default_nettype wire

//--- imul_testdata.txt
# columns: operand a, operand b, expected signed 64-bit product a*b, all hex
# edge cases first, then mixed signs and small values
00000000 00000000 0000000000000000
00000001 00000001 0000000000000001
00000001 FFFFFFFF FFFFFFFFFFFFFFFF
FFFFFFFF FFFFFFFF 0000000000000001
80000000 00000001 FFFFFFFF80000000
80000000 FFFFFFFF 0000000080000000
80000000 80000000 4000000000000000
7FFFFFFF 7FFFFFFF 3FFFFFFF00000001
7FFFFFFF 80000000 C000000080000000
12345678 00000000 0000000000000000
00000000 87654321 0000000000000000
00000002 00000003 0000000000000006
FFFFFFFE 00000003 FFFFFFFFFFFFFFFA
00000010 FFFFFFF0 FFFFFFFFFFFFFF00
00010000 00010000 0000000100000000
FFFF0000 00010000 FFFFFFFF00000000
0000FFFF 0000FFFF 00000000FFFE0001
00001234 00005678 0000000006260060
FFFFEDCC 00005678 FFFFFFFFF9D9FFA0
FFFFEDCC FFFFA988 0000000006260060
7FFFFFFF FFFFFFFF FFFFFFFF80000001
00000003 80000000 FFFFFFFE80000000

//--- sim.f
imul_pkg.sv
imul_lane.sv
imul_dispatch.sv
imul_collect.sv
imul_array.sv
imul_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the imul_array testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module imul_tb -f sim.f -o imul_sim > build.log 2>&1 \
  && ./obj_dir/imul_sim > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log || exit 1
exit 0
